// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := cpu_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/cpu_top.sv
`include "legv8_defs.svh"

module cpu_top (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  output logic [`LEGV8_XLEN-1:0] pc,
  input  logic [31:0]            instr,
  output logic [`LEGV8_XLEN-1:0] mem_addr,
  output logic [`LEGV8_XLEN-1:0] mem_wdata,
  output logic                   mem_read,
  output logic                   mem_write,
  input  logic [`LEGV8_XLEN-1:0] mem_rdata
);

  legv8_pkg::if_id_t      if_id;
  legv8_pkg::id_ex_t      id_ex;
  legv8_pkg::ex_mem_t     ex_mem;
  legv8_pkg::wb_t         wb;
  legv8_pkg::fwd_sel_e    fwd_a;
  legv8_pkg::fwd_sel_e    fwd_b;
  logic                   stall;
  logic [4:0]             rd_index_a;
  logic [4:0]             rd_index_b;
  logic [`LEGV8_XLEN-1:0] rd_data_a;
  logic [`LEGV8_XLEN-1:0] rd_data_b;

  fetch_stage fetch_i (
    .CLOCK (CLOCK),
    .rst_n (rst_n),
    .stall (stall),
    .instr (instr),
    .pc    (pc),
    .if_id (if_id)
  );

  decode_stage decode_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .if_id      (if_id),
    .rd_index_a (rd_index_a),
    .rd_index_b (rd_index_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .stall      (stall),
    .id_ex      (id_ex)
  );

  register_file regfile_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .rd_index_a (rd_index_a),
    .rd_index_b (rd_index_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .wb         (wb)
  );

  forwarding_unit fwd_i (
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .wb     (wb),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b)
  );

  execute_stage execute_i (
    .CLOCK  (CLOCK),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  writeback_stage writeback_i (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .ex_mem    (ex_mem),
    .mem_rdata (mem_rdata),
    .wb        (wb)
  );

  // Data memory port comes straight from the execute/memory register
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.mem_read;
  assign mem_write = ex_mem.mem_write;

endmodule

// File: source/decode_stage.sv
`include "legv8_defs.svh"

module decode_stage (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  legv8_pkg::if_id_t      if_id,
  output logic [4:0]             rd_index_a,
  output logic [4:0]             rd_index_b,
  input  logic [`LEGV8_XLEN-1:0] rd_data_a,
  input  logic [`LEGV8_XLEN-1:0] rd_data_b,
  output logic                   stall,
  output legv8_pkg::id_ex_t      id_ex
);

  legv8_pkg::ctrl_t  ctrl;
  legv8_pkg::id_ex_t id_ex_next;
  logic              is_stur;
  logic              use_a;
  logic              use_b;

  always_comb begin
    ctrl = '0; // Unknown words become bubbles
    if (if_id.valid) begin
      case (if_id.instr.r.opcode)
        `LEGV8_OP_ADD: begin
          ctrl.alu_fn    = legv8_pkg::ALU_ADD;
          ctrl.reg_write = 1'b1;
        end
        `LEGV8_OP_SUB: begin
          ctrl.alu_fn    = legv8_pkg::ALU_SUB;
          ctrl.reg_write = 1'b1;
        end
        `LEGV8_OP_AND: begin
          ctrl.alu_fn    = legv8_pkg::ALU_AND;
          ctrl.reg_write = 1'b1;
        end
        `LEGV8_OP_ORR: begin
          ctrl.alu_fn    = legv8_pkg::ALU_ORR;
          ctrl.reg_write = 1'b1;
        end
        `LEGV8_OP_LDUR: begin
          ctrl.alu_fn     = legv8_pkg::ALU_ADD;
          ctrl.alu_src    = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
        end
        `LEGV8_OP_STUR: begin
          ctrl.alu_fn    = legv8_pkg::ALU_ADD;
          ctrl.alu_src   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign is_stur    = (if_id.instr.d.opcode == `LEGV8_OP_STUR);
  assign rd_index_a = if_id.instr.r.rn;
  assign rd_index_b = is_stur ? if_id.instr.d.rt : if_id.instr.r.rm;

  // Sources actually read by the decoded instruction
  assign use_a = ctrl.reg_write | ctrl.mem_write;
  assign use_b = ctrl.mem_write | (ctrl.reg_write & ~ctrl.alu_src);

  assign stall = id_ex.ctrl.mem_read && (id_ex.rd_idx != `LEGV8_ZERO_REG) &&
                 ((use_a && id_ex.rd_idx == rd_index_a) ||
                  (use_b && id_ex.rd_idx == rd_index_b));

  always_comb begin
    id_ex_next.ctrl    = ctrl;
    id_ex_next.rn_data = rd_data_a;
    id_ex_next.rm_data = rd_data_b;
    id_ex_next.imm     = {{(`LEGV8_XLEN-9){if_id.instr.d.addr[8]}}, if_id.instr.d.addr};
    id_ex_next.rn_idx  = rd_index_a;
    id_ex_next.rm_idx  = rd_index_b;
    id_ex_next.rd_idx  = if_id.instr.r.rd;
  end

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (stall) begin
      id_ex <= '0; // Bubble while the load completes
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

// File: source/execute_stage.sv
`include "legv8_defs.svh"

module execute_stage (
  input  logic                 CLOCK,
  input  logic                 rst_n,
  input  legv8_pkg::id_ex_t    id_ex,
  input  legv8_pkg::fwd_sel_e  fwd_a,
  input  legv8_pkg::fwd_sel_e  fwd_b,
  input  legv8_pkg::wb_t       wb,
  output legv8_pkg::ex_mem_t   ex_mem
);

  logic [`LEGV8_XLEN-1:0] op_a;
  logic [`LEGV8_XLEN-1:0] op_b_reg; // Also the store data
  logic [`LEGV8_XLEN-1:0] op_b;
  logic [`LEGV8_XLEN-1:0] alu_result;

  always_comb begin
    case (fwd_a)
      legv8_pkg::FWD_MEM: op_a = ex_mem.alu_result;
      legv8_pkg::FWD_WB:  op_a = wb.data;
      default:            op_a = id_ex.rn_data;
    endcase
    case (fwd_b)
      legv8_pkg::FWD_MEM: op_b_reg = ex_mem.alu_result;
      legv8_pkg::FWD_WB:  op_b_reg = wb.data;
      default:            op_b_reg = id_ex.rm_data;
    endcase
  end

  assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b_reg;

  always_comb begin
    case (id_ex.ctrl.alu_fn)
      legv8_pkg::ALU_AND: alu_result = op_a & op_b;
      legv8_pkg::ALU_ORR: alu_result = op_a | op_b;
      legv8_pkg::ALU_ADD: alu_result = op_a + op_b;
      legv8_pkg::ALU_SUB: alu_result = op_a - op_b;
      default:            alu_result = '0;
    endcase
  end

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= op_b_reg;
      ex_mem.rd_idx     <= id_ex.rd_idx;
    end
  end

  // Memory port carries one access at a time
  assert property (@(posedge CLOCK) disable iff (!rst_n)
    !(ex_mem.mem_read && ex_mem.mem_write));

  // Bypass paths from later stages always deliver defined data
  assert property (@(posedge CLOCK) disable iff (!rst_n)
    !$isunknown({op_a, op_b_reg}));

endmodule

// File: source/fetch_stage.sv
`include "legv8_defs.svh"

module fetch_stage (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic                   stall,
  input  legv8_pkg::instr_u      instr,
  output logic [`LEGV8_XLEN-1:0] pc,
  output legv8_pkg::if_id_t      if_id
);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= '0;
      if_id <= '0;
    end else if (!stall) begin
      pc          <= pc + `LEGV8_XLEN'd4;
      if_id.valid <= 1'b1;
      if_id.pc    <= pc;
      if_id.instr <= instr;
    end
  end

  // Load-use hold freezes the fetch address
  assert property (@(posedge CLOCK) disable iff (!rst_n) stall |=> $stable(pc));

endmodule

// File: source/forwarding_unit.sv
`include "legv8_defs.svh"

module forwarding_unit (
  input  legv8_pkg::id_ex_t    id_ex,
  input  legv8_pkg::ex_mem_t   ex_mem,
  input  legv8_pkg::wb_t       wb,
  output legv8_pkg::fwd_sel_e  fwd_a,
  output legv8_pkg::fwd_sel_e  fwd_b
);

  function automatic legv8_pkg::fwd_sel_e pick_source(input logic [4:0] src);
    legv8_pkg::fwd_sel_e sel;
    sel = legv8_pkg::FWD_REG;
    if (ex_mem.reg_write && ex_mem.rd_idx != `LEGV8_ZERO_REG && ex_mem.rd_idx == src) begin
      sel = legv8_pkg::FWD_MEM; // Youngest producer wins
    end else if (wb.we && wb.idx != `LEGV8_ZERO_REG && wb.idx == src) begin
      sel = legv8_pkg::FWD_WB;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_source(id_ex.rn_idx);
    fwd_b = pick_source(id_ex.rm_idx);
  end

endmodule

// File: source/legv8_defs.svh
`ifndef LEGV8_DEFS_SVH
`define LEGV8_DEFS_SVH

// Datapath and address width
`define LEGV8_XLEN 64

// Architectural register file
`define LEGV8_REG_COUNT 32
`define LEGV8_ZERO_REG 5'd31

// R-format opcodes
`define LEGV8_OP_ADD 11'b10001011000
`define LEGV8_OP_SUB 11'b11001011000
`define LEGV8_OP_AND 11'b10001010000
`define LEGV8_OP_ORR 11'b10101010000

// D-format opcodes
`define LEGV8_OP_LDUR 11'b11111000010
`define LEGV8_OP_STUR 11'b11111000000

`endif

// File: source/legv8_pkg.sv
`include "legv8_defs.svh"

package legv8_pkg;

  typedef struct packed {
    logic [10:0] opcode;
    logic [4:0]  rm;
    logic [5:0]  shamt;
    logic [4:0]  rn;
    logic [4:0]  rd;
  } r_fmt_t;

  typedef struct packed {
    logic [10:0] opcode;
    logic [8:0]  addr; // Signed byte offset
    logic [1:0]  op2;
    logic [4:0]  rn;
    logic [4:0]  rt;
  } d_fmt_t;

  // One fetched word, decoded as either format
  typedef union packed {
    r_fmt_t r;
    d_fmt_t d;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_ORR = 4'b0001,
    ALU_ADD = 4'b0010,
    ALU_SUB = 4'b0110
  } alu_fn_e;

  typedef struct packed {
    alu_fn_e alu_fn;
    logic    alu_src;    // Offset as second operand
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwd_sel_e;

  typedef struct packed {
    logic                   valid;
    logic [`LEGV8_XLEN-1:0] pc;
    instr_u                 instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t                  ctrl;
    logic [`LEGV8_XLEN-1:0] rn_data;
    logic [`LEGV8_XLEN-1:0] rm_data;  // Rm, or Rt for stores
    logic [`LEGV8_XLEN-1:0] imm;
    logic [4:0]             rn_idx;
    logic [4:0]             rm_idx;
    logic [4:0]             rd_idx;
  } id_ex_t;

  typedef struct packed {
    logic                   mem_read;
    logic                   mem_write;
    logic                   reg_write;
    logic                   mem_to_reg;
    logic [`LEGV8_XLEN-1:0] alu_result;
    logic [`LEGV8_XLEN-1:0] store_data;
    logic [4:0]             rd_idx;
  } ex_mem_t;

  typedef struct packed {
    logic                   reg_write;
    logic                   mem_to_reg;
    logic [`LEGV8_XLEN-1:0] alu_result;
    logic [`LEGV8_XLEN-1:0] load_data;
    logic [4:0]             rd_idx;
  } mem_wb_t;

  typedef struct packed {
    logic                   we;
    logic [4:0]             idx;
    logic [`LEGV8_XLEN-1:0] data;
  } wb_t;

endpackage

// File: source/register_file.sv
`include "legv8_defs.svh"

module register_file (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic [4:0]             rd_index_a,
  input  logic [4:0]             rd_index_b,
  output logic [`LEGV8_XLEN-1:0] rd_data_a,
  output logic [`LEGV8_XLEN-1:0] rd_data_b,
  input  legv8_pkg::wb_t         wb
);

  logic [`LEGV8_XLEN-1:0] regs [`LEGV8_REG_COUNT-1]; // XZR has no storage
  logic                   wr_en;

  assign wr_en = wb.we && (wb.idx != `LEGV8_ZERO_REG);

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `LEGV8_REG_COUNT - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.idx] <= wb.data;
    end
  end

  // Same-cycle write is visible to decode
  assign rd_data_a = (rd_index_a == `LEGV8_ZERO_REG)       ? '0 :
                     (wr_en && wb.idx == rd_index_a)       ? wb.data :
                                                             regs[rd_index_a];
  assign rd_data_b = (rd_index_b == `LEGV8_ZERO_REG)       ? '0 :
                     (wr_en && wb.idx == rd_index_b)       ? wb.data :
                                                             regs[rd_index_b];

endmodule

// File: source/writeback_stage.sv
`include "legv8_defs.svh"

module writeback_stage (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  legv8_pkg::ex_mem_t     ex_mem,
  input  logic [`LEGV8_XLEN-1:0] mem_rdata,
  output legv8_pkg::wb_t         wb
);

  legv8_pkg::mem_wb_t mem_wb;

  always_ff @(posedge CLOCK or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= mem_rdata; // Only meaningful for loads
      mem_wb.rd_idx     <= ex_mem.rd_idx;
    end
  end

  assign wb.we   = mem_wb.reg_write;
  assign wb.idx  = mem_wb.rd_idx;
  assign wb.data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// File: sources.f
+incdir+source
source/legv8_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/forwarding_unit.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
verification/store_checker.sv
verification/cpu_tb.sv

// File: verification/cpu_tb.sv
`include "legv8_defs.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS = 5;
  localparam int MAX_PROG  = 24;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (8 + MAX_PROG + 20) + 100;

  logic                   CLOCK;
  logic                   rst_n;
  logic [`LEGV8_XLEN-1:0] pc;
  logic [31:0]            instr;
  logic [`LEGV8_XLEN-1:0] mem_addr;
  logic [`LEGV8_XLEN-1:0] mem_wdata;
  logic [`LEGV8_XLEN-1:0] mem_rdata;
  logic                   mem_read;
  logic                   mem_write;
  logic [31:0]            imem [64];
  logic [`LEGV8_XLEN-1:0] dmem [64];
  logic [`LEGV8_XLEN-1:0] dmem_init [64];
  logic [31:0]            program_q [$];
  int                     seed;
  int                     pass_count;
  int                     fail_count;

  cpu_top dut_i (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_rdata (mem_rdata)
  );

  store_checker chk_i (
    .CLOCK      (CLOCK),
    .rst_n      (rst_n),
    .mem_write  (mem_write),
    .mem_read   (mem_read),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .prog       (imem),
    .init_mem   (dmem_init),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  assign instr     = imem[pc[7:2]];
  assign mem_rdata = dmem[mem_addr[5:0]];

  always @(posedge CLOCK) begin
    if (mem_write) begin
      dmem[mem_addr[5:0]] <= mem_wdata;
    end
  end

  initial begin
    CLOCK = 1'b0;
    forever #4 CLOCK = ~CLOCK;
  end

  function automatic logic [31:0] r_type(input logic [10:0] op, input logic [4:0] rd,
                                         input logic [4:0] rn, input logic [4:0] rm);
    return {op, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] d_type(input logic [10:0] op, input logic [4:0] rt,
                                         input logic [4:0] rn, input logic [8:0] off);
    return {op, off, 2'b00, rn, rt};
  endfunction

  // Mostly X0..X7 so random code has dependencies
  function automatic logic [4:0] pick_reg();
    int r;
    r = $unsigned($random(seed)) % 9;
    return (r == 8) ? 5'd31 : 5'(r);
  endfunction

  task automatic build_random(input int n);
    logic [10:0] ops [6];
    logic [10:0] op;
    ops = '{`LEGV8_OP_ADD, `LEGV8_OP_SUB, `LEGV8_OP_AND,
            `LEGV8_OP_ORR, `LEGV8_OP_LDUR, `LEGV8_OP_STUR};
    program_q = {};
    for (int i = 0; i < n; i++) begin
      op = ops[$unsigned($random(seed)) % 6];
      if (op == `LEGV8_OP_LDUR || op == `LEGV8_OP_STUR) begin
        program_q.push_back(d_type(op, pick_reg(), pick_reg(), 9'($random(seed))));
      end else begin
        program_q.push_back(r_type(op, pick_reg(), pick_reg(), pick_reg()));
      end
    end
  endtask

  task automatic run_test(input string name);
    logic [`LEGV8_XLEN-1:0] end_pc;
    @(posedge CLOCK);
    #1 rst_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i]      = (i < program_q.size()) ? program_q[i] : 32'd0; // Zero words are bubbles
      dmem_init[i] = {$random(seed), $random(seed)};
      dmem[i]      = dmem_init[i];
    end
    end_pc = `LEGV8_XLEN'(4 * (program_q.size() + 4)); // Last store has left the pipe
    repeat (8) @(posedge CLOCK);
    chk_i.start_test(name, program_q.size());
    #1 rst_n = 1'b1;
    while (pc < end_pc) begin
      @(posedge CLOCK);
      #1;
    end
    @(posedge CLOCK);
    #1;
    chk_i.end_test();
  endtask

  initial begin
    seed  = 9196;
    rst_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i]      = 32'd0;
      dmem[i]      = '0;
      dmem_init[i] = '0;
    end

    program_q = '{d_type(`LEGV8_OP_LDUR, 1, 31, 0), d_type(`LEGV8_OP_LDUR, 2, 31, 8),
                  r_type(`LEGV8_OP_ADD, 3, 1, 2), r_type(`LEGV8_OP_SUB, 4, 3, 1),
                  r_type(`LEGV8_OP_AND, 5, 4, 3), r_type(`LEGV8_OP_ORR, 6, 5, 4),
                  d_type(`LEGV8_OP_STUR, 3, 31, 16), d_type(`LEGV8_OP_STUR, 4, 31, 24),
                  d_type(`LEGV8_OP_STUR, 5, 31, 32), d_type(`LEGV8_OP_STUR, 6, 31, 40)};
    run_test("alu_chain");

    program_q = '{d_type(`LEGV8_OP_LDUR, 1, 31, 0), r_type(`LEGV8_OP_ADD, 2, 1, 1),
                  d_type(`LEGV8_OP_STUR, 2, 31, 8), d_type(`LEGV8_OP_LDUR, 3, 31, 16),
                  d_type(`LEGV8_OP_STUR, 3, 31, 24)};
    run_test("load_use");

    program_q = '{d_type(`LEGV8_OP_LDUR, 1, 31, 0), r_type(`LEGV8_OP_ADD, 2, 1, 1),
                  d_type(`LEGV8_OP_STUR, 2, 31, 40), d_type(`LEGV8_OP_LDUR, 3, 31, 40),
                  d_type(`LEGV8_OP_STUR, 3, 31, 48)};
    run_test("store_reload");

    program_q = '{d_type(`LEGV8_OP_LDUR, 1, 31, 0), r_type(`LEGV8_OP_ADD, 31, 1, 1),
                  d_type(`LEGV8_OP_STUR, 31, 31, 8), r_type(`LEGV8_OP_ORR, 2, 31, 1),
                  d_type(`LEGV8_OP_STUR, 2, 31, 16), r_type(`LEGV8_OP_AND, 3, 1, 31),
                  d_type(`LEGV8_OP_STUR, 3, 31, 24), d_type(`LEGV8_OP_LDUR, 31, 31, 0),
                  d_type(`LEGV8_OP_STUR, 31, 31, 32)};
    run_test("zero_register");

    build_random(MAX_PROG);
    run_test("random_program");

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLOCK);
    $display("Run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verification/store_checker.sv
`include "legv8_defs.svh"

module store_checker (
  input  logic                   CLOCK,
  input  logic                   rst_n,
  input  logic                   mem_write,
  input  logic                   mem_read,
  input  logic [`LEGV8_XLEN-1:0] mem_addr,
  input  logic [`LEGV8_XLEN-1:0] mem_wdata,
  input  logic [31:0]            prog [64],
  input  logic [`LEGV8_XLEN-1:0] init_mem [64],
  output int                     pass_count,
  output int                     fail_count
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic                   is_load;
    logic [`LEGV8_XLEN-1:0] addr;
    logic [`LEGV8_XLEN-1:0] data;  // Store data, zero for loads
  } access_t;

  typedef access_t access_q_t [$];

  access_q_t expected;
  access_t   exp_access;
  access_t   actual;
  string     test_name;
  int        seen;
  bit        test_ok;
  bit        active;

  initial begin
    pass_count = 0;
    fail_count = 0;
    active     = 1'b0;
  end

  // In-order model of the kept instructions
  function automatic access_q_t reference_accesses(input int len);
    logic [`LEGV8_XLEN-1:0] regs [32];
    logic [`LEGV8_XLEN-1:0] mem [64];
    logic [`LEGV8_XLEN-1:0] a;
    logic [`LEGV8_XLEN-1:0] b;
    logic [`LEGV8_XLEN-1:0] addr;
    logic [`LEGV8_XLEN-1:0] res;
    logic                   wr;
    legv8_pkg::instr_u      w;
    access_q_t              accesses;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0; // Entry 31 is XZR and is never written
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = init_mem[i];
    end
    for (int i = 0; i < len; i++) begin
      w    = prog[i];
      a    = regs[w.r.rn];
      b    = regs[w.r.rm];
      addr = a + {{(`LEGV8_XLEN-9){w.d.addr[8]}}, w.d.addr};
      wr   = 1'b1;
      res  = '0;
      case (w.r.opcode)
        `LEGV8_OP_ADD:  res = a + b;
        `LEGV8_OP_SUB:  res = a - b;
        `LEGV8_OP_AND:  res = a & b;
        `LEGV8_OP_ORR:  res = a | b;
        `LEGV8_OP_LDUR: begin
          res = mem[addr[5:0]];
          accesses.push_back('{1'b1, addr, '0});
        end
        `LEGV8_OP_STUR: begin
          wr = 1'b0;
          accesses.push_back('{1'b0, addr, regs[w.d.rt]});
          mem[addr[5:0]] = regs[w.d.rt];
        end
        default: wr = 1'b0;
      endcase
      if (wr && w.r.rd != `LEGV8_ZERO_REG) begin
        regs[w.r.rd] = res;
      end
    end
    return accesses;
  endfunction

  task automatic start_test(input string name, input int len);
    test_name = name;
    expected  = reference_accesses(len);
    seen      = 0;
    test_ok   = 1'b1;
    active    = 1'b1;
  endtask

  task automatic end_test();
    active = 1'b0;
    if (seen < expected.size()) begin
      $display("%s ended after %0d of %0d expected memory accesses",
               test_name, seen, expected.size());
      test_ok = 1'b0;
    end
    if (test_ok) begin
      pass_count++;
      $display("%s: passed, %0d memory accesses checked", test_name, seen);
    end else begin
      fail_count++;
      $display("%s: failed", test_name);
    end
  endtask

  // Access is committed on this edge
  always @(posedge CLOCK) begin
    if (active && rst_n && (mem_write || mem_read)) begin
      actual = '{mem_read, mem_addr, mem_read ? '0 : mem_wdata};
      if (seen >= expected.size()) begin
        $display("%s made an unexpected extra %s of %h to address %h",
                 test_name, mem_read ? "load" : "store", actual.data, mem_addr);
        test_ok = 1'b0;
      end else begin
        exp_access = expected[seen];
        if (exp_access !== actual) begin
          $display("Mismatch in %s access %0d: expected %s %h at %h, actual %s %h at %h",
                   test_name, seen, exp_access.is_load ? "load" : "store",
                   exp_access.data, exp_access.addr, actual.is_load ? "load" : "store",
                   actual.data, actual.addr);
          test_ok = 1'b0;
        end
      end
      seen++;
    end
  end

endmodule
